// ==== all.f ====
+incdir+dv
hdl/decode_pkg.sv
hdl/register_file.sv
hdl/inst_decoder.sv
hdl/operand_bypass.sv
hdl/issue_unit.sv
hdl/decode_stage.sv
dv/decode_stage_tb.sv

// ==== dv/decode_vectors.svh ====
// columns: pc, inst, fwd {ex,mem,wb}, ld {ex,mem}, fwd dest, ex data (mem +1, wb +2),
// hold, rf {rs,rt} from model, rs, rt, dest, reg_we, alu_op,
// {illegal,load,store,src1 sa,src1 pc,src2 imm,src2 uimm,src2 8}, br, target
task automatic load_vectors();
    add_row("addu", row_t'{32'h100, r_word(1, 2, 3, 0, fn_addu), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b11, 32'h0, 32'h0, 5'd3, 1'b1, 12'h001, 8'h00, 2'b00, 32'h0});
    add_row("subu", row_t'{32'h104, r_word(4, 5, 6, 0, fn_subu), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b11, 32'h0, 32'h0, 5'd6, 1'b1, 12'h002, 8'h00, 2'b00, 32'h0});
    add_row("sltu", row_t'{32'h108, r_word(10, 11, 12, 0, fn_sltu), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b11, 32'h0, 32'h0, 5'd12, 1'b1, 12'h008, 8'h00, 2'b00, 32'h0});
    add_row("nor", row_t'{32'h10c, r_word(13, 14, 15, 0, fn_nor), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b11, 32'h0, 32'h0, 5'd15, 1'b1, 12'h020, 8'h00, 2'b00, 32'h0});
    add_row("sll", row_t'{32'h110, r_word(0, 13, 14, 5, fn_sll), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b11, 32'h0, 32'h0, 5'd14, 1'b1, 12'h100, 8'h10, 2'b00, 32'h0});
    add_row("sra", row_t'{32'h114, r_word(0, 15, 16, 3, fn_sra), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b11, 32'h0, 32'h0, 5'd16, 1'b1, 12'h400, 8'h10, 2'b00, 32'h0});
    add_row("addiu", row_t'{32'h118, i_word(op_addiu, 17, 18, 16'hfff0), 3'b000, 2'b00, 5'd0,
        32'h0, 4'd0, 2'b11, 32'h0, 32'h0, 5'd18, 1'b1, 12'h001, 8'h04, 2'b00, 32'h0});
    add_row("ori", row_t'{32'h11c, i_word(op_ori, 19, 20, 16'h00ff), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b11, 32'h0, 32'h0, 5'd20, 1'b1, 12'h040, 8'h02, 2'b00, 32'h0});
    add_row("lui", row_t'{32'h120, i_word(op_lui, 0, 21, 16'h1234), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b11, 32'h0, 32'h0, 5'd21, 1'b1, 12'h800, 8'h04, 2'b00, 32'h0});
    add_row("lw", row_t'{32'h124, i_word(op_lw, 22, 23, 16'h0004), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b11, 32'h0, 32'h0, 5'd23, 1'b1, 12'h001, 8'h44, 2'b00, 32'h0});
    add_row("sw", row_t'{32'h128, i_word(op_sw, 24, 25, 16'h0008), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b11, 32'h0, 32'h0, 5'd0, 1'b0, 12'h001, 8'h24, 2'b00, 32'h0});
    add_row("illegal", row_t'{32'h12c, i_word(6'h3f, 1, 2, 16'h0000), 3'b000, 2'b00, 5'd0,
        32'h0, 4'd0, 2'b11, 32'h0, 32'h0, 5'd0, 1'b0, 12'h000, 8'h80, 2'b00, 32'h0});
    // forwarding never applies to register 0
    add_row("zero", row_t'{32'h130, r_word(0, 0, 1, 0, fn_addu), 3'b111, 2'b00, 5'd0,
        32'hdead0000, 4'd0, 2'b00, 32'h0, 32'h0, 5'd1, 1'b1, 12'h001, 8'h00, 2'b00, 32'h0});
    add_row("fwd_ex", row_t'{32'h134, r_word(5, 5, 2, 0, fn_addu), 3'b111, 2'b00, 5'd5,
        32'h11110000, 4'd0, 2'b00, 32'h11110000, 32'h11110000, 5'd2, 1'b1, 12'h001, 8'h00,
        2'b00, 32'h0});
    add_row("fwd_mem", row_t'{32'h138, r_word(6, 6, 2, 0, fn_addu), 3'b011, 2'b00, 5'd6,
        32'h22220000, 4'd0, 2'b00, 32'h22220001, 32'h22220001, 5'd2, 1'b1, 12'h001, 8'h00,
        2'b00, 32'h0});
    add_row("fwd_wb", row_t'{32'h13c, r_word(7, 8, 2, 0, fn_addu), 3'b001, 2'b00, 5'd7,
        32'h33330000, 4'd0, 2'b01, 32'h33330002, 32'h0, 5'd2, 1'b1, 12'h001, 8'h00, 2'b00, 32'h0});
    add_row("load_ex", row_t'{32'h140, r_word(9, 10, 2, 0, fn_addu), 3'b100, 2'b10, 5'd9,
        32'h44440000, 4'd3, 2'b01, 32'h44440000, 32'h0, 5'd2, 1'b1, 12'h001, 8'h00, 2'b00, 32'h0});
    add_row("load_mem", row_t'{32'h144, r_word(11, 12, 2, 0, fn_addu), 3'b010, 2'b01, 5'd12,
        32'h55550000, 4'd3, 2'b10, 32'h0, 32'h55550001, 5'd2, 1'b1, 12'h001, 8'h00, 2'b00, 32'h0});
    add_row("load_shadow", row_t'{32'h148, r_word(13, 1, 2, 0, fn_addu), 3'b110, 2'b01, 5'd13,
        32'h66660000, 4'd0, 2'b01, 32'h66660000, 32'h0, 5'd2, 1'b1, 12'h001, 8'h00, 2'b00, 32'h0});
    add_row("beq", row_t'{32'h1000, i_word(op_beq, 0, 0, 16'h0004), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b00, 32'h0, 32'h0, 5'd0, 1'b0, 12'h000, 8'h00, 2'b11, 32'h1014});
    add_row("bne", row_t'{32'h2000, i_word(op_bne, 0, 0, 16'hfffe), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b00, 32'h0, 32'h0, 5'd31, 1'b0, 12'h000, 8'h00, 2'b10, 32'h1ffc});
    add_row("bltz", row_t'{32'h3000, i_word(op_regimm, 3, 0, 16'h0010), 3'b100, 2'b00, 5'd3,
        32'h80000000, 4'd0, 2'b00, 32'h80000000, 32'h0, 5'd0, 1'b0, 12'h000, 8'h00, 2'b11,
        32'h3044});
    add_row("bgez", row_t'{32'h3004, i_word(op_regimm, 3, 1, 16'h0010), 3'b100, 2'b00, 5'd3,
        32'h80000000, 4'd0, 2'b01, 32'h80000000, 32'h0, 5'd0, 1'b0, 12'h000, 8'h00, 2'b10,
        32'h3048});
    add_row("bgtz", row_t'{32'h4000, i_word(op_bgtz, 4, 0, 16'hffff), 3'b100, 2'b00, 5'd4, 32'h0,
        4'd0, 2'b00, 32'h0, 32'h0, 5'd31, 1'b0, 12'h000, 8'h00, 2'b10, 32'h4000});
    add_row("blez", row_t'{32'h4004, i_word(op_blez, 4, 0, 16'hffff), 3'b100, 2'b00, 5'd4, 32'h0,
        4'd0, 2'b00, 32'h0, 32'h0, 5'd31, 1'b0, 12'h000, 8'h00, 2'b11, 32'h4004});
    add_row("j", row_t'{32'h10000000, j_word(op_j, 26'h0000100), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b00, 32'h0, 32'h0, 5'd0, 1'b0, 12'h000, 8'h00, 2'b11, 32'h10000400});
    add_row("jal", row_t'{32'h20000000, j_word(op_jal, 26'h0000040), 3'b000, 2'b00, 5'd0, 32'h0,
        4'd0, 2'b00, 32'h0, 32'h0, 5'd31, 1'b1, 12'h001, 8'h09, 2'b11, 32'h20000100});
    add_row("jr", row_t'{32'h500, r_word(8, 0, 0, 0, fn_jr), 3'b100, 2'b00, 5'd8, 32'h00abc000,
        4'd0, 2'b00, 32'h00abc000, 32'h0, 5'd0, 1'b0, 12'h000, 8'h00, 2'b11, 32'h00abc000});
    add_row("jalr", row_t'{32'h504, r_word(8, 0, 31, 0, fn_jalr), 3'b100, 2'b00, 5'd8,
        32'h00def000, 4'd0, 2'b00, 32'h00def000, 32'h0, 5'd31, 1'b1, 12'h001, 8'h09, 2'b11,
        32'h00def000});
endtask

// ==== dv/decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb
    import decode_pkg::*;
;

    typedef struct packed {
        logic [data_w-1:0]   pc;
        inst_t               inst;
        logic [2:0]          fwd;
        logic [1:0]          ld;
        logic [reg_w-1:0]    fdest;
        logic [data_w-1:0]   fdata;
        logic [3:0]          hold;
        logic [1:0]          rf;
        logic [data_w-1:0]   exp_rs;
        logic [data_w-1:0]   exp_rt;
        logic [reg_w-1:0]    dest;
        logic                we;
        logic [alu_op_w-1:0] alu;
        logic [7:0]          cls;
        logic [1:0]          br;
        logic [data_w-1:0]   target;
    } row_t;

    logic clk, reset, fetch_valid, fetch_ready, issue_valid, issue_ready;
    logic [data_w-1:0] fetch_pc, fetch_inst, issue_pc, issue_rs_value, issue_rt_value;
    logic [alu_op_w-1:0] issue_alu_op;
    logic [imm_w-1:0] issue_imm;
    logic issue_src1_is_sa, issue_src1_is_pc, issue_src2_is_imm, issue_src2_is_uimm;
    logic issue_src2_is_8, issue_load, issue_store, issue_reg_we, issue_illegal;
    logic [reg_w-1:0] issue_dest, ex_fwd_dest, mem_fwd_dest, wb_dest;
    logic br_valid, br_taken, ex_fwd_valid, ex_fwd_load, mem_fwd_valid, mem_fwd_load, wb_we;
    logic [data_w-1:0] br_target, ex_fwd_data, mem_fwd_data, wb_data;

    row_t              rows [$];
    string             names [$];
    logic [data_w-1:0] reg_model [num_regs];
    logic [31:0]       lcg_state = 32'd85712;
    int                num_rows = 0;

    decode_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic inst_t r_word(int rs, int rt, int rd, int sa, logic [5:0] fn);
        inst_t w;
        w.r = {op_special, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn};
        return w;
    endfunction

    function automatic inst_t i_word(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        inst_t w;
        w.i = {op, rs[4:0], rt[4:0], imm};
        return w;
    endfunction

    function automatic inst_t j_word(logic [5:0] op, logic [25:0] index);
        inst_t w;
        w.j = {op, index};
        return w;
    endfunction

    task automatic add_row(string name, row_t v);
        names.push_back(name);
        rows.push_back(v);
    endtask

    `include "decode_vectors.svh"

    task automatic fail_value(string tag, logic [data_w-1:0] exp, logic [data_w-1:0] act);
        $display("FAILED %s expected %h actual %h", tag, exp, act);
        $display("TB FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic check_word(string tag, logic [data_w-1:0] exp, logic [data_w-1:0] act);
        if (exp !== act) fail_value(tag, exp, act);
    endtask

    task automatic check_index(string tag, logic [reg_w-1:0] exp, logic [reg_w-1:0] act);
        if (exp !== act) fail_value(tag, {27'd0, exp}, {27'd0, act});
    endtask

    task automatic check_alu(string tag, logic [alu_op_w-1:0] exp, logic [alu_op_w-1:0] act);
        if (exp !== act) fail_value(tag, {20'd0, exp}, {20'd0, act});
    endtask

    task automatic check_flag(string tag, logic exp, logic act);
        if (exp !== act) fail_value(tag, {31'd0, exp}, {31'd0, act});
    endtask

    task automatic drive_forwarding(row_t v);
        ex_fwd_valid  = v.fwd[2];
        ex_fwd_load   = v.ld[1];
        mem_fwd_valid = v.fwd[1];
        mem_fwd_load  = v.ld[0];
        wb_we         = v.fwd[0];
        ex_fwd_dest   = v.fdest;
        mem_fwd_dest  = v.fdest;
        wb_dest       = v.fdest;
        ex_fwd_data   = v.fdata;
        mem_fwd_data  = v.fdata + 32'd1;
        wb_data       = v.fdata + 32'd2;
    endtask

    task automatic run_row(int n);
        row_t              v;
        string             nm;
        logic [31:0]       rnd;
        logic              fired;
        logic [data_w-1:0] exp_rs, exp_rt;
        v  = rows[n];
        nm = names[n];
        drive_forwarding(v);
        fetch_valid = 1'b1;
        fetch_pc    = v.pc;
        fetch_inst  = v.inst;
        while (!fetch_ready) @(negedge clk);
        @(negedge clk);
        fetch_valid = 1'b0;
        // a pending load must block the issue
        if (v.hold != 4'd0) begin
            repeat (v.hold) begin
                #1;
                check_flag({nm, " stall"}, 1'b0, issue_valid);
                @(negedge clk);
            end
            ex_fwd_load  = 1'b0;
            mem_fwd_load = 1'b0;
        end
        fired = 1'b0;
        while (!fired) begin
            rnd         = lcg_next();
            issue_ready = rnd[16];
            #1;
            exp_rs = v.rf[1] ? reg_model[v.inst.r.rs] : v.exp_rs;
            exp_rt = v.rf[0] ? reg_model[v.inst.r.rt] : v.exp_rt;
            if (issue_valid) begin
                check_word({nm, " pc"}, v.pc, issue_pc);
                check_index({nm, " dest"}, v.dest, issue_dest);
                check_flag({nm, " reg_we"}, v.we, issue_reg_we);
                check_alu({nm, " alu_op"}, v.alu, issue_alu_op);
                check_word({nm, " imm"}, {16'd0, v.inst[imm_w-1:0]}, {16'd0, issue_imm});
                check_flag({nm, " illegal"}, v.cls[7], issue_illegal);
                check_flag({nm, " load"}, v.cls[6], issue_load);
                check_flag({nm, " store"}, v.cls[5], issue_store);
                check_flag({nm, " src1_is_sa"}, v.cls[4], issue_src1_is_sa);
                check_flag({nm, " src1_is_pc"}, v.cls[3], issue_src1_is_pc);
                check_flag({nm, " src2_is_imm"}, v.cls[2], issue_src2_is_imm);
                check_flag({nm, " src2_is_uimm"}, v.cls[1], issue_src2_is_uimm);
                check_flag({nm, " src2_is_8"}, v.cls[0], issue_src2_is_8);
                check_word({nm, " rs"}, exp_rs, issue_rs_value);
                check_word({nm, " rt"}, exp_rt, issue_rt_value);
            end
            fired = issue_valid && issue_ready;
            check_flag({nm, " br_valid"}, fired && v.br[1], br_valid);
            check_flag({nm, " br_taken"}, fired && v.br[0], br_taken);
            if (fired && v.br[1]) check_word({nm, " br_target"}, v.target, br_target);
            @(negedge clk);
        end
        if (v.fwd[0] && v.fdest != '0) reg_model[v.fdest] = v.fdata + 32'd2;
        drive_forwarding('0);
        issue_ready = 1'b0;
        #1;
        check_flag({nm, " no duplicate"}, 1'b0, issue_valid);
    endtask

    initial begin
        wait (num_rows > 0);
        #((num_rows + 2) * 40 * 40);
        $display("watchdog: the run did not finish in time");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        reset = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc = '0;
        fetch_inst = '0;
        issue_ready = 1'b0;
        drive_forwarding('0);
        load_vectors();
        num_rows = rows.size();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_flag("reset fetch_ready", 1'b1, fetch_ready);
        check_flag("reset issue_valid", 1'b0, issue_valid);
        check_flag("reset br_valid", 1'b0, br_valid);
        reg_model[0] = '0;
        // preload through the writeback port
        for (int r = 1; r < num_regs; r++) begin
            @(negedge clk);
            wb_we        = 1'b1;
            wb_dest      = r[4:0];
            wb_data      = lcg_next();
            reg_model[r] = wb_data;
        end
        @(negedge clk);
        wb_we = 1'b0;
        for (int n = 0; n < num_rows; n++) begin
            run_row(n);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== hdl/decode_pkg.sv ====
package decode_pkg;

    localparam int data_w   = 32;
    localparam int reg_w    = 5;
    localparam int num_regs = 32;
    localparam int imm_w    = 16;
    localparam int alu_op_w = 12;
    localparam int num_src  = 2;
    localparam int src_rs   = 0;
    localparam int src_rt   = 1;

    localparam logic [reg_w-1:0] link_reg = 5'd31;

    // one-hot alu op bit positions
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // branch condition kinds
    localparam logic [2:0] br_eq  = 3'd0;
    localparam logic [2:0] br_ne  = 3'd1;
    localparam logic [2:0] br_ltz = 3'd2;
    localparam logic [2:0] br_gez = 3'd3;
    localparam logic [2:0] br_gtz = 3'd4;
    localparam logic [2:0] br_lez = 3'd5;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    localparam logic [4:0] rt_bltz = 5'h00;
    localparam logic [4:0] rt_bgez = 5'h01;

    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] sa;
            logic [5:0] func;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  op;
            logic [25:0] index;
        } j;
    } inst_t;

endpackage

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                fetch_valid,
    output logic                fetch_ready,
    input  logic [data_w-1:0]   fetch_pc,
    input  logic [data_w-1:0]   fetch_inst,
    output logic                issue_valid,
    input  logic                issue_ready,
    output logic [data_w-1:0]   issue_pc,
    output logic [alu_op_w-1:0] issue_alu_op,
    output logic [imm_w-1:0]    issue_imm,
    output logic                issue_src1_is_sa,
    output logic                issue_src1_is_pc,
    output logic                issue_src2_is_imm,
    output logic                issue_src2_is_uimm,
    output logic                issue_src2_is_8,
    output logic                issue_load,
    output logic                issue_store,
    output logic                issue_reg_we,
    output logic [reg_w-1:0]    issue_dest,
    output logic                issue_illegal,
    output logic [data_w-1:0]   issue_rs_value,
    output logic [data_w-1:0]   issue_rt_value,
    output logic                br_valid,
    output logic                br_taken,
    output logic [data_w-1:0]   br_target,
    input  logic                ex_fwd_valid,
    input  logic                ex_fwd_load,
    input  logic [reg_w-1:0]    ex_fwd_dest,
    input  logic [data_w-1:0]   ex_fwd_data,
    input  logic                mem_fwd_valid,
    input  logic                mem_fwd_load,
    input  logic [reg_w-1:0]    mem_fwd_dest,
    input  logic [data_w-1:0]   mem_fwd_data,
    input  logic                wb_we,
    input  logic [reg_w-1:0]    wb_dest,
    input  logic [data_w-1:0]   wb_data
);

    logic                           stage_valid;
    logic                           issue_fire;
    logic                           is_branch;
    logic                           is_jump_reg;
    logic                           is_jump_abs;
    logic [2:0]                     branch_kind;
    logic [25:0]                    jump_index;
    logic [num_src-1:0][reg_w-1:0]  src_idx;
    logic [num_src-1:0]             src_used;
    logic [num_src-1:0][data_w-1:0] rf_rdata;
    logic [num_src-1:0][data_w-1:0] src_value;
    logic [num_src-1:0]             src_stall;

    inst_decoder decoder_i (
        .clk(clk), .reset(reset),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_inst(fetch_inst),
        .issue_fire(issue_fire), .fetch_ready(fetch_ready),
        .stage_valid(stage_valid), .stage_pc(issue_pc),
        .alu_op(issue_alu_op), .imm(issue_imm), .jump_index(jump_index),
        .src1_is_sa(issue_src1_is_sa), .src1_is_pc(issue_src1_is_pc),
        .src2_is_imm(issue_src2_is_imm), .src2_is_uimm(issue_src2_is_uimm),
        .src2_is_8(issue_src2_is_8), .load(issue_load), .store(issue_store),
        .reg_we(issue_reg_we), .dest(issue_dest), .illegal(issue_illegal),
        .is_branch(is_branch), .is_jump_reg(is_jump_reg), .is_jump_abs(is_jump_abs),
        .branch_kind(branch_kind), .src_idx(src_idx), .src_used(src_used)
    );

    register_file regfile_i (
        .clk(clk), .raddr(src_idx), .we(wb_we), .waddr(wb_dest), .wdata(wb_data),
        .rdata(rf_rdata)
    );

    // one bypass per source operand
    for (genvar s = 0; s < num_src; s++) begin : g_bypass
        operand_bypass bypass_i (
            .idx(src_idx[s]), .used(src_used[s]), .rf_data(rf_rdata[s]),
            .ex_fwd_valid(ex_fwd_valid), .ex_fwd_load(ex_fwd_load),
            .ex_fwd_dest(ex_fwd_dest), .ex_fwd_data(ex_fwd_data),
            .mem_fwd_valid(mem_fwd_valid), .mem_fwd_load(mem_fwd_load),
            .mem_fwd_dest(mem_fwd_dest), .mem_fwd_data(mem_fwd_data),
            .wb_we(wb_we), .wb_dest(wb_dest), .wb_data(wb_data),
            .value(src_value[s]), .stall(src_stall[s])
        );
    end

    issue_unit issue_i (
        .stage_valid(stage_valid), .stage_pc(issue_pc),
        .src_value(src_value), .src_stall(src_stall),
        .is_branch(is_branch), .is_jump_reg(is_jump_reg), .is_jump_abs(is_jump_abs),
        .branch_kind(branch_kind), .imm(issue_imm), .jump_index(jump_index),
        .issue_ready(issue_ready), .issue_valid(issue_valid), .issue_fire(issue_fire),
        .issue_rs_value(issue_rs_value), .issue_rt_value(issue_rt_value),
        .br_valid(br_valid), .br_taken(br_taken), .br_target(br_target)
    );

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder
    import decode_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          fetch_valid,
    input  logic [data_w-1:0]             fetch_pc,
    input  logic [data_w-1:0]             fetch_inst,
    input  logic                          issue_fire,
    output logic                          fetch_ready,
    output logic                          stage_valid,
    output logic [data_w-1:0]             stage_pc,
    output logic [alu_op_w-1:0]           alu_op,
    output logic [imm_w-1:0]              imm,
    output logic [25:0]                   jump_index,
    output logic                          src1_is_sa,
    output logic                          src1_is_pc,
    output logic                          src2_is_imm,
    output logic                          src2_is_uimm,
    output logic                          src2_is_8,
    output logic                          load,
    output logic                          store,
    output logic                          reg_we,
    output logic [reg_w-1:0]              dest,
    output logic                          illegal,
    output logic                          is_branch,
    output logic                          is_jump_reg,
    output logic                          is_jump_abs,
    output logic [2:0]                    branch_kind,
    output logic [num_src-1:0][reg_w-1:0] src_idx,
    output logic [num_src-1:0]            src_used
);

    inst_t inst_q;
    logic  special, sa_zero, rs_zero, rt_zero, rd_zero;
    logic  inst_addu, inst_subu, inst_slt, inst_sltu, inst_and, inst_or, inst_xor, inst_nor;
    logic  inst_sll, inst_srl, inst_sra, inst_jr, inst_jalr;
    logic  inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic  inst_lw, inst_sw, inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic  inst_j, inst_jal, r_alu, i_alu;

    assign fetch_ready = !stage_valid || issue_fire;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (fetch_ready) begin
            stage_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) begin
            stage_pc <= fetch_pc;
            inst_q   <= fetch_inst;
        end
    end

    assign special = inst_q.r.op == op_special;
    assign sa_zero = inst_q.r.sa == '0;
    assign rs_zero = inst_q.r.rs == '0;
    assign rt_zero = inst_q.r.rt == '0;
    assign rd_zero = inst_q.r.rd == '0;

    assign inst_addu  = special && inst_q.r.func == fn_addu && sa_zero;
    assign inst_subu  = special && inst_q.r.func == fn_subu && sa_zero;
    assign inst_slt   = special && inst_q.r.func == fn_slt && sa_zero;
    assign inst_sltu  = special && inst_q.r.func == fn_sltu && sa_zero;
    assign inst_and   = special && inst_q.r.func == fn_and && sa_zero;
    assign inst_or    = special && inst_q.r.func == fn_or && sa_zero;
    assign inst_xor   = special && inst_q.r.func == fn_xor && sa_zero;
    assign inst_nor   = special && inst_q.r.func == fn_nor && sa_zero;
    assign inst_sll   = special && inst_q.r.func == fn_sll && rs_zero;
    assign inst_srl   = special && inst_q.r.func == fn_srl && rs_zero;
    assign inst_sra   = special && inst_q.r.func == fn_sra && rs_zero;
    assign inst_jr    = special && inst_q.r.func == fn_jr && rt_zero && rd_zero && sa_zero;
    assign inst_jalr  = special && inst_q.r.func == fn_jalr && rt_zero && sa_zero;
    assign inst_addiu = inst_q.i.op == op_addiu;
    assign inst_slti  = inst_q.i.op == op_slti;
    assign inst_sltiu = inst_q.i.op == op_sltiu;
    assign inst_andi  = inst_q.i.op == op_andi;
    assign inst_ori   = inst_q.i.op == op_ori;
    assign inst_xori  = inst_q.i.op == op_xori;
    assign inst_lui   = inst_q.i.op == op_lui && rs_zero;
    assign inst_lw    = inst_q.i.op == op_lw;
    assign inst_sw    = inst_q.i.op == op_sw;
    assign inst_beq   = inst_q.i.op == op_beq;
    assign inst_bne   = inst_q.i.op == op_bne;
    assign inst_bgtz  = inst_q.i.op == op_bgtz && rt_zero;
    assign inst_blez  = inst_q.i.op == op_blez && rt_zero;
    assign inst_bltz  = inst_q.i.op == op_regimm && inst_q.i.rt == rt_bltz;
    assign inst_bgez  = inst_q.i.op == op_regimm && inst_q.i.rt == rt_bgez;
    assign inst_j     = inst_q.j.op == op_j;
    assign inst_jal   = inst_q.j.op == op_jal;

    // register-register ops reading both rs and rt
    assign r_alu = inst_addu | inst_subu | inst_slt | inst_sltu |
                   inst_and | inst_or | inst_xor | inst_nor;
    assign i_alu = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori | inst_xori;

    assign alu_op[alu_add]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal | inst_jalr;
    assign alu_op[alu_sub]  = inst_subu;
    assign alu_op[alu_slt]  = inst_slt | inst_slti;
    assign alu_op[alu_sltu] = inst_sltu | inst_sltiu;
    assign alu_op[alu_and]  = inst_and | inst_andi;
    assign alu_op[alu_nor]  = inst_nor;
    assign alu_op[alu_or]   = inst_or | inst_ori;
    assign alu_op[alu_xor]  = inst_xor | inst_xori;
    assign alu_op[alu_sll]  = inst_sll;
    assign alu_op[alu_srl]  = inst_srl;
    assign alu_op[alu_sra]  = inst_sra;
    assign alu_op[alu_lui]  = inst_lui;

    assign is_branch   = inst_beq | inst_bne | inst_bltz | inst_bgez | inst_bgtz | inst_blez;
    assign is_jump_reg = inst_jr | inst_jalr;
    assign is_jump_abs = inst_j | inst_jal;

    assign illegal = !(r_alu | inst_sll | inst_srl | inst_sra | i_alu | inst_lui |
                       inst_lw | inst_sw | is_branch | is_jump_reg | is_jump_abs);

    assign imm          = inst_q.i.imm;
    assign jump_index   = inst_q.j.index;
    assign src1_is_sa   = inst_sll | inst_srl | inst_sra;
    assign src1_is_pc   = inst_jal | inst_jalr;
    assign src2_is_8    = inst_jal | inst_jalr;
    assign src2_is_imm  = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
    assign src2_is_uimm = inst_andi | inst_ori | inst_xori;
    assign load         = inst_lw;
    assign store        = inst_sw;
    assign reg_we       = !(illegal | inst_sw | is_branch | inst_j | inst_jr);

    assign dest = inst_jal                 ? link_reg    :
                  (i_alu | inst_lui | inst_lw) ? inst_q.i.rt :
                                               inst_q.r.rd;

    always_comb begin
        if (inst_bne) begin
            branch_kind = br_ne;
        end else if (inst_bltz) begin
            branch_kind = br_ltz;
        end else if (inst_bgez) begin
            branch_kind = br_gez;
        end else if (inst_bgtz) begin
            branch_kind = br_gtz;
        end else if (inst_blez) begin
            branch_kind = br_lez;
        end else begin
            branch_kind = br_eq;
        end
    end

    assign src_idx[src_rs]  = inst_q.r.rs;
    assign src_idx[src_rt]  = inst_q.r.rt;
    assign src_used[src_rs] = r_alu | i_alu | inst_lw | inst_sw | is_branch | is_jump_reg;
    assign src_used[src_rt] = r_alu | inst_sll | inst_srl | inst_sra | inst_sw |
                              inst_beq | inst_bne;

endmodule

// ==== hdl/issue_unit.sv ====
`timescale 1ns/1ps

module issue_unit
    import decode_pkg::*;
(
    input  logic                           stage_valid,
    input  logic [data_w-1:0]              stage_pc,
    input  logic [num_src-1:0][data_w-1:0] src_value,
    input  logic [num_src-1:0]             src_stall,
    input  logic                           is_branch,
    input  logic                           is_jump_reg,
    input  logic                           is_jump_abs,
    input  logic [2:0]                     branch_kind,
    input  logic [imm_w-1:0]               imm,
    input  logic [25:0]                    jump_index,
    input  logic                           issue_ready,
    output logic                           issue_valid,
    output logic                           issue_fire,
    output logic [data_w-1:0]              issue_rs_value,
    output logic [data_w-1:0]              issue_rt_value,
    output logic                           br_valid,
    output logic                           br_taken,
    output logic [data_w-1:0]              br_target
);

    logic [data_w-1:0] pc_plus4;
    logic [data_w-1:0] target;
    logic              cond;
    logic              rs_eq_rt;
    logic              rs_ltz;
    logic              rs_gtz;

    assign issue_valid    = stage_valid && !(|src_stall);
    assign issue_fire     = issue_valid && issue_ready;
    assign issue_rs_value = src_value[src_rs];
    assign issue_rt_value = src_value[src_rt];

    assign rs_eq_rt = issue_rs_value == issue_rt_value;
    assign rs_ltz   = issue_rs_value[data_w-1];
    assign rs_gtz   = !rs_ltz && (|issue_rs_value);

    always_comb begin
        case (branch_kind)
            br_eq:   cond = rs_eq_rt;
            br_ne:   cond = !rs_eq_rt;
            br_ltz:  cond = rs_ltz;
            br_gez:  cond = !rs_ltz;
            br_gtz:  cond = rs_gtz;
            br_lez:  cond = !rs_gtz;
            default: cond = 1'b0;
        endcase
    end

    assign pc_plus4 = stage_pc + 32'd4;

    always_comb begin
        if (is_jump_reg) begin
            target = issue_rs_value;
        end else if (is_jump_abs) begin
            target = {pc_plus4[31:28], jump_index, 2'b00};
        end else begin
            target = pc_plus4 + {{(data_w-imm_w-2){imm[imm_w-1]}}, imm, 2'b00};
        end
    end

    // only meaningful during the transfer cycle
    assign br_valid  = issue_fire && (is_branch || is_jump_reg || is_jump_abs);
    assign br_taken  = br_valid && (cond || is_jump_reg || is_jump_abs);
    assign br_target = br_valid ? target : '0;

endmodule

// ==== hdl/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass
    import decode_pkg::*;
(
    input  logic [reg_w-1:0]  idx,
    input  logic              used,
    input  logic [data_w-1:0] rf_data,
    input  logic              ex_fwd_valid,
    input  logic              ex_fwd_load,
    input  logic [reg_w-1:0]  ex_fwd_dest,
    input  logic [data_w-1:0] ex_fwd_data,
    input  logic              mem_fwd_valid,
    input  logic              mem_fwd_load,
    input  logic [reg_w-1:0]  mem_fwd_dest,
    input  logic [data_w-1:0] mem_fwd_data,
    input  logic              wb_we,
    input  logic [reg_w-1:0]  wb_dest,
    input  logic [data_w-1:0] wb_data,
    output logic [data_w-1:0] value,
    output logic              stall
);

    logic can_match;
    logic ex_hit;
    logic mem_hit;
    logic wb_hit;

    // register 0 is never forwarded
    assign can_match = used && idx != '0;

    assign ex_hit  = can_match && ex_fwd_valid && ex_fwd_dest == idx;
    assign mem_hit = can_match && mem_fwd_valid && mem_fwd_dest == idx;
    assign wb_hit  = can_match && wb_we && wb_dest == idx;

    // load data not ready yet
    assign stall = (ex_hit && ex_fwd_load) || (!ex_hit && mem_hit && mem_fwd_load);

    always_comb begin
        if (ex_hit) begin
            value = ex_fwd_data;
        end else if (mem_hit) begin
            value = mem_fwd_data;
        end else if (wb_hit) begin
            value = wb_data;
        end else begin
            value = rf_data;
        end
    end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file
    import decode_pkg::*;
(
    input  logic                             clk,
    input  logic [num_src-1:0][reg_w-1:0]    raddr,
    input  logic                             we,
    input  logic [reg_w-1:0]                 waddr,
    input  logic [data_w-1:0]                wdata,
    output logic [num_src-1:0][data_w-1:0]   rdata
);

    logic [data_w-1:0] regs [num_regs];

    // register 0 never written
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        for (int i = 0; i < num_src; i++) begin
            if (raddr[i] == '0) begin
                rdata[i] = '0;
            end else begin
                rdata[i] = regs[raddr[i]];
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module decode_stage_tb -o decode_stage_tb
./obj_dir/decode_stage_tb | tee sim.log
grep -q "TB PASSED" sim.log
echo "simulation passed"
